// ==== include/poker_macros.svh ====
`ifndef POKER_MACROS_SVH
`define POKER_MACROS_SVH

// hand and card geometry
`define HAND_SIZE 5
`define RANK_W 4
`define SUIT_W 2
// suit bits sit above the rank bits
`define CARD_W 6
`define CAT_W 4

// rank limits, ace counts low except in the ten-to-ace straight
`define RANK_ACE 1
`define RANK_TEN 10
`define RANK_KING 13

// category codes, higher code beats lower
`define CAT_HIGH_CARD 0
`define CAT_ONE_PAIR 1
`define CAT_TWO_PAIRS 2
`define CAT_THREE 3
`define CAT_STRAIGHT 4
`define CAT_FLUSH 5
`define CAT_FULL_HOUSE 6
`define CAT_FOUR 7
`define CAT_STRAIGHT_FLUSH 8

`endif

// ==== verilog/pokerPkg.sv ====
`include "poker_macros.svh"

package pokerPkg;

	// one card, suit in the upper bits
	typedef logic [`CARD_W-1:0] cardT;

	// rank field of a card
	typedef logic [`RANK_W-1:0] rankT;

	// suit field of a card
	typedef logic [`SUIT_W-1:0] suitT;

	// category code as seen at the output
	typedef logic [`CAT_W-1:0] handTypeT;

	// a full hand, card 0 first
	typedef cardT handT [`HAND_SIZE];

endpackage

// ==== verilog/handIf.sv ====
`timescale 1ns/1ps

// registered hand between capture and classifier
interface handIf import pokerPkg::*; ();

	// held hand, stable while vld is high and rdy is low
	handT cards;

	// capture has a hand
	logic vld;

	// classifier can take the hand this cycle
	logic rdy;

	// capture side
	modport source (
		output cards,
		output vld,
		input  rdy
	);

	// classifier side, handshake only
	modport sink (
		input  vld,
		output rdy
	);

	// analyzers only look at the cards
	modport monitor (
		input cards
	);

endinterface

// ==== verilog/featureIf.sv ====
`timescale 1ns/1ps

// analyzer flags into the classifier
interface featureIf;

	// rank multiplicity flags
	logic four;
	logic fullHouse;
	logic three;
	logic twoPairs;
	logic onePair;

	// suit and sequence flags
	logic flush;
	logic straight;

	// driven by the rank matcher
	modport rank (
		output four,
		output fullHouse,
		output three,
		output twoPairs,
		output onePair
	);

	// driven by the flush/straight detector
	modport seq (
		output flush,
		output straight
	);

	// classifier reads everything
	modport sink (
		input four,
		input fullHouse,
		input three,
		input twoPairs,
		input onePair,
		input flush,
		input straight
	);

endinterface

// ==== verilog/handCapture.sv ====
`timescale 1ns/1ps

module handCapture import pokerPkg::*; (
	input  logic clk,
	input  logic rstN,
	input  logic inVld,
	output logic inRdy,
	input  cardT card0,
	input  cardT card1,
	input  cardT card2,
	input  cardT card3,
	input  cardT card4,
	handIf.source hand
);

	// register is free this cycle
	logic load;

	// empty, or the current hand leaves on this edge
	assign load = !hand.vld || hand.rdy;

	// upstream may push whenever the slot frees up
	assign inRdy = load;

	// valid bit, cleared by reset
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			hand.vld <= 1'b0;
		end else if (load) begin
			hand.vld <= inVld;
		end
	end

	// card payload
	// only written on an accepted transfer so the held hand stays put under stall
	always_ff @(posedge clk) begin
		if (load && inVld) begin
			hand.cards[0] <= card0;
			hand.cards[1] <= card1;
			hand.cards[2] <= card2;
			hand.cards[3] <= card3;
			hand.cards[4] <= card4;
		end
	end

endmodule

// ==== verilog/rankMatcher.sv ====
`timescale 1ns/1ps

`include "poker_macros.svh"

module rankMatcher import pokerPkg::*; (
	handIf.monitor hand,
	featureIf.rank feat
);

	// rank of each held card
	rankT rank [`HAND_SIZE];

	// pairwise rank equality, symmetric, diagonal set
	logic same [`HAND_SIZE][`HAND_SIZE];

	// cards sharing the rank of card i, itself included (1 to 5)
	logic [2:0] cnt [`HAND_SIZE];

	// cards that sit in an exact pair
	logic [2:0] pairCards;

	always_comb begin
		// strip suits
		for (int i = 0; i < `HAND_SIZE; i++) begin
			rank[i] = hand.cards[i][`RANK_W-1:0];
		end

		// ten compares, mirrored into the lower half
		for (int i = 0; i < `HAND_SIZE; i++) begin
			same[i][i] = 1'b1;
			for (int j = i + 1; j < `HAND_SIZE; j++) begin
				same[i][j] = (rank[i] == rank[j]);
				same[j][i] = same[i][j];
			end
		end

		// row sums
		for (int i = 0; i < `HAND_SIZE; i++) begin
			cnt[i] = '0;
			for (int j = 0; j < `HAND_SIZE; j++) begin
				cnt[i] = cnt[i] + 3'(same[i][j]);
			end
		end

		feat.four = 1'b0;
		feat.three = 1'b0;
		pairCards = '0;
		for (int i = 0; i < `HAND_SIZE; i++) begin
			// five equal ranks also land here
			if (cnt[i] >= 3'd4) begin
				feat.four = 1'b1;
			end
			if (cnt[i] == 3'd3) begin
				feat.three = 1'b1;
			end
			if (cnt[i] == 3'd2) begin
				pairCards = pairCards + 3'd1;
			end
		end

		// every pair rank shows up on two cards
		feat.onePair = (pairCards != 3'd0);
		feat.twoPairs = (pairCards == 3'd4);
		// counts differ, so the pair rank is never the triple rank
		feat.fullHouse = feat.three && feat.onePair;
	end

endmodule

// ==== verilog/sequenceFlushDetector.sv ====
`timescale 1ns/1ps

`include "poker_macros.svh"

module sequenceFlushDetector import pokerPkg::*; (
	handIf.monitor hand,
	featureIf.seq feat
);

	// split fields
	rankT rank [`HAND_SIZE];
	suitT suit [`HAND_SIZE];

	// smallest and largest rank
	rankT lo;
	rankT hi;

	// no repeated rank
	logic distinct;
	// every rank is a real card, ace to king
	logic inRange;
	// every rank is ace or ten and up
	logic allHigh;
	// run of five consecutive ranks
	logic lowRun;

	always_comb begin
		for (int i = 0; i < `HAND_SIZE; i++) begin
			rank[i] = hand.cards[i][`RANK_W-1:0];
			suit[i] = hand.cards[i][`CARD_W-1:`RANK_W];
		end

		lo = rank[0];
		hi = rank[0];
		inRange = 1'b1;
		allHigh = 1'b1;
		feat.flush = 1'b1;
		for (int i = 0; i < `HAND_SIZE; i++) begin
			if (rank[i] < lo) begin
				lo = rank[i];
			end
			if (rank[i] > hi) begin
				hi = rank[i];
			end
			// 0, 14 and 15 knock out any straight
			inRange &= (rank[i] >= rankT'(`RANK_ACE)) && (rank[i] <= rankT'(`RANK_KING));
			allHigh &= (rank[i] == rankT'(`RANK_ACE)) || (rank[i] >= rankT'(`RANK_TEN));
			feat.flush &= (suit[i] == suit[0]);
		end

		distinct = 1'b1;
		for (int i = 0; i < `HAND_SIZE; i++) begin
			for (int j = i + 1; j < `HAND_SIZE; j++) begin
				distinct &= (rank[i] != rank[j]);
			end
		end

		// ace counts low here, so a-2-3-4-5 is caught as a plain run
		lowRun = ((hi - lo) == rankT'(`HAND_SIZE - 1));

		// five distinct from {A,10,J,Q,K} is exactly the ace-high straight
		feat.straight = distinct && inRange && (lowRun || allHigh);
	end

endmodule

// ==== verilog/handClassifier.sv ====
`timescale 1ns/1ps

`include "poker_macros.svh"

module handClassifier import pokerPkg::*; (
	input  logic clk,
	input  logic rstN,
	handIf.sink hand,
	featureIf.sink feat,
	output logic outVld,
	input  logic outRdy,
	output handTypeT handType
);

	// output register free this cycle
	logic take;

	// category of the hand now in capture
	handTypeT nextType;

	// empty, or the current result drains this edge
	assign take = !outVld || outRdy;
	assign hand.rdy = take;

	// highest category wins
	always_comb begin
		if (feat.flush && feat.straight) begin
			nextType = handTypeT'(`CAT_STRAIGHT_FLUSH);
		end else if (feat.four) begin
			nextType = handTypeT'(`CAT_FOUR);
		end else if (feat.fullHouse) begin
			nextType = handTypeT'(`CAT_FULL_HOUSE);
		end else if (feat.flush) begin
			nextType = handTypeT'(`CAT_FLUSH);
		end else if (feat.straight) begin
			nextType = handTypeT'(`CAT_STRAIGHT);
		end else if (feat.three) begin
			// full house already taken above, so this is a bare triple
			nextType = handTypeT'(`CAT_THREE);
		end else if (feat.twoPairs) begin
			nextType = handTypeT'(`CAT_TWO_PAIRS);
		end else if (feat.onePair) begin
			nextType = handTypeT'(`CAT_ONE_PAIR);
		end else begin
			nextType = handTypeT'(`CAT_HIGH_CARD);
		end
	end

	// result valid
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			outVld <= 1'b0;
		end else if (take) begin
			outVld <= hand.vld;
		end
	end

	// result code, held while the sink stalls
	always_ff @(posedge clk) begin
		if (take && hand.vld) begin
			handType <= nextType;
		end
	end

endmodule

// ==== verilog/pokerTop.sv ====
`timescale 1ns/1ps

module pokerTop import pokerPkg::*; (
	input  logic clk,
	input  logic rstN,
	input  logic inVld,
	output logic inRdy,
	input  cardT card0,
	input  cardT card1,
	input  cardT card2,
	input  cardT card3,
	input  cardT card4,
	output logic outVld,
	input  logic outRdy,
	output handTypeT handType
);

	// capture to analyzers and classifier
	handIf hIf ();

	// analyzer flags
	featureIf fIf ();

	// stage 1, registered hand
	handCapture uCapture (
		.clk   (clk),
		.rstN  (rstN),
		.inVld (inVld),
		.inRdy (inRdy),
		.card0 (card0),
		.card1 (card1),
		.card2 (card2),
		.card3 (card3),
		.card4 (card4),
		.hand  (hIf.source)
	);

	// combinational, same cycle as the held hand
	rankMatcher uRank (
		.hand (hIf.monitor),
		.feat (fIf.rank)
	);

	sequenceFlushDetector uSeq (
		.hand (hIf.monitor),
		.feat (fIf.seq)
	);

	// stage 2, priority pick and output register
	handClassifier uClassify (
		.clk      (clk),
		.rstN     (rstN),
		.hand     (hIf.sink),
		.feat     (fIf.sink),
		.outVld   (outVld),
		.outRdy   (outRdy),
		.handType (handType)
	);

endmodule

// ==== test/poker_assert.sv ====
`timescale 1ns/1ps

module pokerAssert import pokerPkg::*; (
	input logic     clk,
	input logic     rstN,
	input logic     inRdy,
	input logic     outVld,
	input logic     outRdy,
	input handTypeT handType
);

	// a stalled result keeps its valid and its code
	holdWhileStalled: assert property (@(posedge clk) disable iff (!rstN)
		outVld && !outRdy |=> outVld && $stable(handType))
		else $error("result changed while the output was stalled");

	// no result can leave during reset
	quietInReset: assert property (@(posedge clk) !rstN |-> !outVld)
		else $error("outVld high during reset");

	// empty pipe takes a hand right after reset
	readyAfterReset: assert property (@(posedge clk) $rose(rstN) |-> inRdy)
		else $error("inRdy low in the first cycle after reset");

	// code is driven whenever it is offered
	knownResult: assert property (@(posedge clk) disable iff (!rstN)
		outVld |-> !$isunknown(handType))
		else $error("handType unknown while outVld is high");

endmodule

// one copy per pokerTop
bind pokerTop pokerAssert uAssert (
	.clk      (clk),
	.rstN     (rstN),
	.inRdy    (inRdy),
	.outVld   (outVld),
	.outRdy   (outRdy),
	.handType (handType)
);

// ==== test/pokerChecker.sv ====
`timescale 1ns/1ps

module pokerChecker import pokerPkg::*; (
	input logic     clk,
	input logic     rstN,
	input logic     inVld,
	input logic     inRdy,
	input logic     outVld,
	input logic     outRdy,
	input handTypeT handType,
	input logic     streaming
);

	// hands in flight, oldest first
	logic [29:0] handQ [$];
	handTypeT typeQ [$];

	// head of the queues at an output transfer
	logic [29:0] gotHand;
	handTypeT want;

	int mismatchCount = 0;
	int unexpectedCount = 0;
	int stallCount = 0;

	// called by the stimulus for every hand it offers
	task automatic pushExpected(input logic [29:0] cards, input handTypeT code);
		handQ.push_back(cards);
		typeQ.push_back(code);
	endtask

	function automatic int pendingCount();
		return typeQ.size();
	endfunction

	// pre-edge values, DUT registers update after this
	always @(posedge clk) begin
		if (rstN && outVld && outRdy) begin
			if (typeQ.size() == 0) begin
				unexpectedCount++;
				$display("result %0d at %0t arrived with no hand outstanding", handType, $time);
			end else begin
				gotHand = handQ.pop_front();
				want = typeQ.pop_front();
				if (handType !== want) begin
					mismatchCount++;
					$display("ERR %0t: hand %h %h %h %h %h expected %0d got %0d", $time,
						gotHand[29:24], gotHand[23:18], gotHand[17:12], gotHand[11:6],
						gotHand[5:0], want, handType);
				end
			end
		end
		// sink always ready, so capture must never push back
		if (rstN && streaming && inVld && !inRdy) begin
			stallCount++;
			$display("input was held off at %0t although the output was always ready", $time);
		end
	end

endmodule

// ==== test/tbPokerTop.sv ====
`timescale 1ns/1ps

module tbPokerTop import pokerPkg::*; ();

	logic clk = 1'b0;
	logic rstN;
	logic inVld;
	logic inRdy;
	logic outVld;
	logic outRdy;
	handTypeT handType;
	// five cards, card0 in the top bits
	logic [29:0] handBus;
	// sink held ready, used for the throughput run
	logic streaming;

	logic [29:0] vecHand [$];
	handTypeT vecType [$];
	integer seed = 32'h3ce4_3a2d;
	int cycles = 0;
	int limit = 0;
	int errTotal;
	logic fileOk;

	pokerTop uut (
		.clk      (clk),
		.rstN     (rstN),
		.inVld    (inVld),
		.inRdy    (inRdy),
		.card0    (handBus[29:24]),
		.card1    (handBus[23:18]),
		.card2    (handBus[17:12]),
		.card3    (handBus[11:6]),
		.card4    (handBus[5:0]),
		.outVld   (outVld),
		.outRdy   (outRdy),
		.handType (handType)
	);

	pokerChecker chk (
		.clk       (clk),
		.rstN      (rstN),
		.inVld     (inVld),
		.inRdy     (inRdy),
		.outVld    (outVld),
		.outRdy    (outRdy),
		.handType  (handType),
		.streaming (streaming)
	);

	always #10 clk = ~clk;

	// sink stalls on about one edge in four
	always @(negedge clk) begin
		outRdy = streaming || (($random(seed) & 3) != 0);
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles >= limit) begin
			$display("run timed out after %0d cycles with %0d results never delivered",
				cycles, chk.pendingCount());
			$display("Test failures found");
			$finish;
		end
	end

	// lines starting with # are notes
	task automatic readGolden();
		int fd;
		int n;
		string line;
		cardT c0, c1, c2, c3, c4;
		int code;
		fd = $fopen("test/poker_golden.txt", "r");
		fileOk = (fd != 0);
		while (fileOk && !$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			n = $sscanf(line, "%h %h %h %h %h %h", c0, c1, c2, c3, c4, code);
			if (n == 6) begin
				vecHand.push_back({c0, c1, c2, c3, c4});
				vecType.push_back(handTypeT'(code));
			end
		end
		if (fileOk) begin
			$fclose(fd);
		end
	endtask

	// hold valid and cards until the handshake
	task automatic sendHand(input logic [29:0] cards, input handTypeT code);
		@(negedge clk);
		inVld = 1'b1;
		handBus = cards;
		chk.pushExpected(cards, code);
		@(posedge clk);
		while (!inRdy) begin
			@(posedge clk);
		end
	endtask

	task automatic runAll();
		limit = 40 * vecHand.size() + 200;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		for (int i = 0; i < vecHand.size(); i++) begin
			sendHand(vecHand[i], vecType[i]);
			// random stalls from here on
			if (i == 11) begin
				streaming <= 1'b0;
			end
		end
		@(negedge clk);
		inVld = 1'b0;
		while (chk.pendingCount() != 0) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
		errTotal = chk.mismatchCount + chk.unexpectedCount + chk.stallCount;
		$display("%0d hands, %0d mismatches, %0d unexpected results, %0d input stalls",
			vecHand.size(), chk.mismatchCount, chk.unexpectedCount, chk.stallCount);
		if (errTotal == 0 && vecHand.size() != 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	endtask

	initial begin
		rstN = 1'b0;
		inVld = 1'b0;
		handBus = '0;
		outRdy = 1'b0;
		streaming = 1'b1;
		readGolden();
		if (!fileOk) begin
			$display("could not open the golden file test/poker_golden.txt");
			$display("Test failures found");
			$finish;
		end else begin
			runAll();
		end
	end

endmodule

// ==== project.f ====
+incdir+include
verilog/pokerPkg.sv
verilog/handIf.sv
verilog/featureIf.sv
verilog/handCapture.sv
verilog/rankMatcher.sv
verilog/sequenceFlushDetector.sv
verilog/handClassifier.sv
verilog/pokerTop.sv
test/poker_assert.sv
test/pokerChecker.sv
test/tbPokerTop.sv

// ==== test/poker_golden.txt ====
# card0 card1 card2 card3 card4 in hex (suit in bits 5:4, rank in bits 3:0)
# last column is the expected category code, 0 high card up to 8 straight flush
02 15 29 3B 0D 0
0B 1C 2D 31 02 0
03 13 27 38 0C 1
04 14 29 39 0D 2
07 17 27 32 0A 3
05 16 27 38 09 4
01 12 23 34 05 4
0A 1B 2C 3D 01 4
22 25 29 2B 2D 5
13 13 18 1A 1C 5
06 16 26 39 09 6
08 18 28 38 02 7
0C 1C 2C 3C 0C 7
34 35 36 37 38 8
0A 0B 0C 0D 01 8
21 22 23 24 25 8
00 11 12 13 14 0
0E 1F 2E 3F 01 2
0A 1B 2C 3D 0E 0
0F 1F 2F 33 04 3
02 02 02 05 05 6
07 07 07 07 03 7
19 19 19 12 14 5
31 31 35 35 3D 5
1D 09 3B 2A 0C 4
01 21 3D 1C 05 1
03 14 25 36 16 1
02 13 24 35 07 0
02 13 24 35 06 4
01 11 21 0D 1D 6
01 31 02 12 2B 2
0D 1D 2D 04 39 3
00 10 20 30 00 7
19 1A 1B 1C 1D 8
0D 03 08 0B 06 5
0D 11 22 33 04 0
0A 1B 2C 3D 0F 0
2A 2A 2B 2C 2D 5
